/* rtl/mrd_pkg.sv */
package mrd_pkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------
	localparam int NUM_BANKS  = 7;
	localparam int MAX_LANES  = 5;
	localparam int MAX_STAGES = 5;
	localparam int MAX_N      = 1024;
	// one extra word so that address MAX_N-1 still fits
	localparam int BANK_DEPTH = (MAX_N + NUM_BANKS - 1) / NUM_BANKS;

	typedef logic [15:0]                     sample_t;
	typedef logic [$clog2(MAX_N)-1:0]        addr_t;
	typedef logic [$clog2(BANK_DEPTH)-1:0]   bank_addr_t;
	typedef logic [2:0]                      bank_idx_t;
	typedef logic [2:0]                      factor_t;
	typedef logic [2:0]                      stage_t;
	typedef logic [11:0]                     wb_addr_t;
	typedef logic [31:0]                     wb_data_t;

	// unused lane marker, one past the last bank
	localparam bank_idx_t BANK_NONE = 3'd7;

	// ----------------------------------------
	// register map, bit 11 selects registers
	// ----------------------------------------
	localparam wb_addr_t REG_FACTORS = 12'h800;
	localparam wb_addr_t REG_CONTROL = 12'h801;
	localparam wb_addr_t REG_STATUS  = 12'h802;

	// field positions
	localparam int FACT_NUM_LSB   = 0;
	localparam int FACT_NF_LSB    = 4;
	localparam int FACT_NF_STRIDE = 4;
	localparam int CTRL_START     = 0;
	localparam int CTRL_STAGE_LSB = 4;
	localparam int STAT_BUSY      = 0;
	localparam int STAT_STAGE_LSB = 4;

	typedef enum logic [1:0] {IDLE, RD, WAIT_END} ctrl_state_t;

endpackage

/* rtl/mrd_bank_rd_if.sv */
`timescale 1ns/1ps

interface mrd_bank_rd_if;
	import mrd_pkg::*;

	// one read port per bank
	logic       [NUM_BANKS-1:0] rden;
	bank_addr_t [NUM_BANKS-1:0] rdaddr;

	// bank data, valid the cycle after rden
	sample_t    [NUM_BANKS-1:0] dout_real;
	sample_t    [NUM_BANKS-1:0] dout_imag;

	modport reader (
		output rden,
		output rdaddr,
		input  dout_real,
		input  dout_imag
	);

	modport memory (
		input  rden,
		input  rdaddr,
		output dout_real,
		output dout_imag
	);

endinterface

/* rtl/mrd_group_if.sv */
`timescale 1ns/1ps

interface mrd_group_if;
	import mrd_pkg::*;

	logic                    valid;
	// lane addresses, unused lanes carry zero
	addr_t [MAX_LANES-1:0]   addrs;
	factor_t                 factor;
	// final group of the stage
	logic                    last;

	modport src (
		output valid,
		output addrs,
		output factor,
		output last
	);

	modport dst (
		input  valid,
		input  addrs,
		input  factor,
		input  last
	);

endinterface

/* rtl/mrd_div7.sv */
`timescale 1ns/1ps

module mrd_div7 (
	input  mrd_pkg::addr_t     dividend,
	output mrd_pkg::bank_addr_t quotient,
	output mrd_pkg::bank_idx_t  remainder
);

	logic [16:0] prod;
	logic [7:0]  q_est;
	logic [10:0] r_est;
	logic [10:0] r_fix;
	logic        over;

	// 73/512 sits just below 1/7, so the estimate is at most one low
	assign prod  = dividend * 7'd73;
	assign q_est = prod[16:9];

	// correction step
	assign r_est = {1'b0, dividend} - {3'b000, q_est} * 11'd7;
	assign r_fix = r_est - 11'd7;
	assign over  = (r_est >= 11'd7);

	assign quotient  = over ? q_est + 8'd1 : q_est;
	assign remainder = over ? r_fix[2:0] : r_est[2:0];

endmodule

/* rtl/mrd_bank_mem.sv */
`timescale 1ns/1ps

module mrd_bank_mem (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr_en,
	input  mrd_pkg::addr_t    wr_addr,
	input  mrd_pkg::wb_data_t wr_data,
	mrd_bank_rd_if.memory     rd
);
	import mrd_pkg::*;

	bank_addr_t wr_word;
	bank_idx_t  wr_bank;
	sample_t    q_real [NUM_BANKS];
	sample_t    q_imag [NUM_BANKS];

	// host side address split
	mrd_div7 u_div7 (
		.dividend  (wr_addr),
		.quotient  (wr_word),
		.remainder (wr_bank)
	);

	// ----------------------------------------
	// banks
	// ----------------------------------------
	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		sample_t real_mem [BANK_DEPTH];
		sample_t imag_mem [BANK_DEPTH];

		// low half real, high half imag
		always_ff @(posedge clk)
		begin
			if (wr_en && wr_bank == b)
			begin
				real_mem[wr_word] <= wr_data[15:0];
				imag_mem[wr_word] <= wr_data[31:16];
			end
		end

		// holds last word while rden is low
		always_ff @(posedge clk)
		begin
			if (!rst_n)
			begin
				q_real[b] <= '0;
				q_imag[b] <= '0;
			end
			else if (rd.rden[b])
			begin
				q_real[b] <= real_mem[rd.rdaddr[b]];
				q_imag[b] <= imag_mem[rd.rdaddr[b]];
			end
		end
	end

	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			rd.dout_real[b] = q_real[b];
			rd.dout_imag[b] = q_imag[b];
		end
	end

endmodule

/* rtl/mrd_addr_gen.sv */
`timescale 1ns/1ps

module mrd_addr_gen (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       start,
	input  mrd_pkg::stage_t                            stage,
	input  mrd_pkg::factor_t [mrd_pkg::MAX_STAGES-1:0] nf,
	input  mrd_pkg::stage_t                            num_factors,
	mrd_group_if.src                                   grp
);
	import mrd_pkg::*;

	logic [10:0]           stride_c, groups_c;
	logic [10:0]           stride_r, span_r, groups_r;
	factor_t               factor_r;
	logic                  run;
	logic [10:0]           g_cnt, inner, blk_base, base;
	logic                  last_grp;
	addr_t [MAX_LANES-1:0] lane_addr;

	// stride = factors after the stage, groups = all factors but this one
	always_comb
	begin
		stride_c = 11'd1;
		groups_c = 11'd1;
		for (int j = 0; j < MAX_STAGES; j++)
		begin
			if (j < num_factors && j > stage)
				stride_c = stride_c * nf[j];
			if (j < num_factors && j != stage)
				groups_c = groups_c * nf[j];
		end
	end

	// ----------------------------------------
	// group walk
	// ----------------------------------------
	assign base     = blk_base + inner;
	assign last_grp = (g_cnt == groups_r - 11'd1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			run      <= 1'b0;
			g_cnt    <= '0;
			inner    <= '0;
			blk_base <= '0;
			stride_r <= 11'd1;
			span_r   <= '0;
			groups_r <= '0;
			factor_r <= '0;
		end
		else if (start)
		begin
			stride_r <= stride_c;
			span_r   <= stride_c * nf[stage];
			groups_r <= groups_c;
			factor_r <= nf[stage];
			run      <= 1'b1;
			g_cnt    <= '0;
			inner    <= '0;
			blk_base <= '0;
		end
		else if (run)
		begin
			g_cnt <= g_cnt + 11'd1;
			if (last_grp)
				run <= 1'b0;
			// inner wraps at the stride, then jump one block
			if (inner == stride_r - 11'd1)
			begin
				inner    <= '0;
				blk_base <= blk_base + span_r;
			end
			else
				inner <= inner + 11'd1;
		end
	end

	for (genvar m = 0; m < MAX_LANES; m++)
	begin : g_lane
		logic [10:0] lane_sum;

		assign lane_sum     = base + 11'(m) * stride_r;
		assign lane_addr[m] = (m < factor_r) ? lane_sum[9:0] : '0;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			grp.valid <= 1'b0;
			grp.last  <= 1'b0;
		end
		else
		begin
			grp.valid <= run;
			grp.last  <= run && last_grp;
		end
	end

	always_ff @(posedge clk)
		grp.addrs <= lane_addr;

	assign grp.factor = factor_r;

endmodule

/* rtl/mrd_fsm_rd.sv */
`timescale 1ns/1ps

module mrd_fsm_rd (
	input  logic                                        clk,
	input  logic                                        rst_n,
	mrd_group_if.dst                                    grp,
	mrd_bank_rd_if.reader                               mem,
	output logic                                        out_valid,
	output mrd_pkg::factor_t                            out_factor,
	output mrd_pkg::bank_idx_t [mrd_pkg::MAX_LANES-1:0] out_bank_index,
	output mrd_pkg::sample_t [mrd_pkg::MAX_LANES-1:0]   out_real,
	output mrd_pkg::sample_t [mrd_pkg::MAX_LANES-1:0]   out_imag,
	output logic                                        rd_end
);
	import mrd_pkg::*;

	bank_addr_t [MAX_LANES-1:0] quo, word_r;
	bank_idx_t  [MAX_LANES-1:0] rem;
	// lane bank indices, one copy per pipe stage
	bank_idx_t  [MAX_LANES-1:0] idx_r, idx_rr, idx_rrr;
	bank_addr_t [NUM_BANKS-1:0] sel_addr;
	logic       [NUM_BANKS-1:0] sel_en;
	logic       [3:1]           vld;
	factor_t    [3:1]           fac;

	// ----------------------------------------
	// stage 1: bank translation
	// ----------------------------------------
	for (genvar k = 0; k < MAX_LANES; k++)
	begin : g_div
		mrd_div7 u_div7 (
			.dividend  (grp.addrs[k]),
			.quotient  (quo[k]),
			.remainder (rem[k])
		);
	end

	always_ff @(posedge clk)
		word_r <= quo;

	// ----------------------------------------
	// stage 2: bank enables
	// ----------------------------------------
	// lanes sit in distinct banks, so at most one lane hits a bank
	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			sel_en[b]   = 1'b0;
			sel_addr[b] = '0;
			for (int k = MAX_LANES - 1; k >= 0; k--)
			begin
				if (idx_r[k] == b)
				begin
					sel_en[b]   = 1'b1;
					sel_addr[b] = word_r[k];
				end
			end
		end
	end

	always_ff @(posedge clk)
		mem.rdaddr <= sel_addr;

	// ----------------------------------------
	// control pipe
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			idx_r          <= {MAX_LANES{BANK_NONE}};
			idx_rr         <= {MAX_LANES{BANK_NONE}};
			idx_rrr        <= {MAX_LANES{BANK_NONE}};
			out_bank_index <= {MAX_LANES{BANK_NONE}};
			mem.rden       <= '0;
			vld            <= '0;
			fac            <= '0;
			out_valid      <= 1'b0;
			out_factor     <= '0;
			rd_end         <= 1'b0;
		end
		else
		begin
			// idle cycles and lanes past the factor are marked unused
			for (int k = 0; k < MAX_LANES; k++)
				idx_r[k] <= (grp.valid && k < grp.factor) ? rem[k] : BANK_NONE;
			mem.rden       <= sel_en;
			idx_rr         <= idx_r;
			idx_rrr        <= idx_rr;
			out_bank_index <= idx_rrr;

			vld[1]    <= grp.valid;
			vld[2]    <= vld[1];
			vld[3]    <= vld[2];
			out_valid <= vld[3];
			// falling edge of the valid run
			rd_end    <= out_valid && !vld[3];

			fac[1]     <= grp.factor;
			fac[2]     <= fac[1];
			fac[3]     <= fac[2];
			out_factor <= fac[3];
		end
	end

	// ----------------------------------------
	// stage 4: lane mux
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		for (int k = 0; k < MAX_LANES; k++)
		begin
			if (idx_rrr[k] == BANK_NONE)
			begin
				out_real[k] <= '0;
				out_imag[k] <= '0;
			end
			else
			begin
				out_real[k] <= mem.dout_real[idx_rrr[k]];
				out_imag[k] <= mem.dout_imag[idx_rrr[k]];
			end
		end
	end

endmodule

/* rtl/mrd_wb_regs.sv */
`timescale 1ns/1ps

module mrd_wb_regs (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       wb_cyc,
	input  logic                                       wb_stb,
	input  logic                                       wb_we,
	input  mrd_pkg::wb_addr_t                          wb_adr,
	input  mrd_pkg::wb_data_t                          wb_dat_i,
	output mrd_pkg::wb_data_t                          wb_dat_o,
	output logic                                       wb_ack,
	output logic                                       wr_en,
	output mrd_pkg::addr_t                             wr_addr,
	output mrd_pkg::wb_data_t                          wr_data,
	output logic                                       start,
	output mrd_pkg::stage_t                            stage,
	output mrd_pkg::factor_t [mrd_pkg::MAX_STAGES-1:0] nf,
	output mrd_pkg::stage_t                            num_factors,
	input  logic                                       last_seen,
	input  logic                                       rd_end
);
	import mrd_pkg::*;

	ctrl_state_t state;
	logic        accept, reg_sel, busy;
	wb_data_t    status_w, factors_w;

	// one accept per request, ack blocks the next cycle
	assign accept  = wb_cyc && wb_stb && !wb_ack;
	assign reg_sel = wb_adr[11];
	assign busy    = (state != IDLE);

	// sample memory is write only
	assign wr_en   = accept && wb_we && !reg_sel;
	assign wr_addr = wb_adr[9:0];
	assign wr_data = wb_dat_i;

	always_comb
	begin
		status_w = '0;
		status_w[STAT_BUSY] = busy;
		status_w[STAT_STAGE_LSB +: 3] = stage;
		factors_w = '0;
		factors_w[FACT_NUM_LSB +: 3] = num_factors;
		for (int j = 0; j < MAX_STAGES; j++)
			factors_w[FACT_NF_LSB + FACT_NF_STRIDE * j +: 3] = nf[j];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_ack      <= 1'b0;
			wb_dat_o    <= '0;
			start       <= 1'b0;
			stage       <= '0;
			nf          <= '0;
			num_factors <= '0;
			state       <= IDLE;
		end
		else
		begin
			wb_ack <= accept;
			start  <= 1'b0;
			if (accept && wb_we && wb_adr == REG_FACTORS)
			begin
				num_factors <= wb_dat_i[FACT_NUM_LSB +: 3];
				for (int j = 0; j < MAX_STAGES; j++)
					nf[j] <= wb_dat_i[FACT_NF_LSB + FACT_NF_STRIDE * j +: 3];
			end
			// start while busy is acked and dropped
			if (accept && wb_we && wb_adr == REG_CONTROL && wb_dat_i[CTRL_START] && !busy)
			begin
				stage <= wb_dat_i[CTRL_STAGE_LSB +: 3];
				start <= 1'b1;
			end
			if (accept && !wb_we)
			begin
				if (wb_adr == REG_STATUS)
					wb_dat_o <= status_w;
				else if (wb_adr == REG_FACTORS)
					wb_dat_o <= factors_w;
				else
					wb_dat_o <= '0;
			end

			case (state)
				IDLE:     if (start) state <= RD;
				RD:       if (last_seen) state <= WAIT_END;
				WAIT_END: if (rd_end) state <= IDLE;
				default:  state <= IDLE;
			endcase
		end
	end

endmodule

/* rtl/mrd_read_top.sv */
`timescale 1ns/1ps

module mrd_read_top (
	input  logic                                        clk,
	input  logic                                        rst_n,
	// wishbone slave
	input  logic                                        wb_cyc,
	input  logic                                        wb_stb,
	input  logic                                        wb_we,
	input  mrd_pkg::wb_addr_t                           wb_adr,
	input  mrd_pkg::wb_data_t                           wb_dat_i,
	output mrd_pkg::wb_data_t                           wb_dat_o,
	output logic                                        wb_ack,
	// butterfly stream
	output logic                                        out_valid,
	output mrd_pkg::factor_t                            out_factor,
	output mrd_pkg::bank_idx_t [mrd_pkg::MAX_LANES-1:0] out_bank_index,
	output mrd_pkg::sample_t [mrd_pkg::MAX_LANES-1:0]   out_real,
	output mrd_pkg::sample_t [mrd_pkg::MAX_LANES-1:0]   out_imag,
	output logic                                        rd_end
);
	import mrd_pkg::*;

	logic                       wr_en;
	addr_t                      wr_addr;
	wb_data_t                   wr_data;
	logic                       start;
	stage_t                     stage;
	factor_t [MAX_STAGES-1:0]   nf;
	stage_t                     num_factors;

	mrd_group_if   grp_if ();
	mrd_bank_rd_if bank_if ();

	mrd_wb_regs u_wb_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.start       (start),
		.stage       (stage),
		.nf          (nf),
		.num_factors (num_factors),
		.last_seen   (grp_if.last),
		.rd_end      (rd_end)
	);

	mrd_bank_mem u_bank_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd      (bank_if.memory)
	);

	mrd_addr_gen u_addr_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.stage       (stage),
		.nf          (nf),
		.num_factors (num_factors),
		.grp         (grp_if.src)
	);

	mrd_fsm_rd u_fsm_rd (
		.clk            (clk),
		.rst_n          (rst_n),
		.grp            (grp_if.dst),
		.mem            (bank_if.reader),
		.out_valid      (out_valid),
		.out_factor     (out_factor),
		.out_bank_index (out_bank_index),
		.out_real       (out_real),
		.out_imag       (out_imag),
		.rd_end         (rd_end)
	);

endmodule

/* testbench/tb_mrd_read.sv */
`timescale 1ns/1ps

module tb_mrd_read;
	import mrd_pkg::*;

	logic                      clk;
	logic                      rst_n;
	logic                      wb_cyc;
	logic                      wb_stb;
	logic                      wb_we;
	wb_addr_t                  wb_adr;
	wb_data_t                  wb_dat_i;
	wb_data_t                  wb_dat_o;
	logic                      wb_ack;
	logic                      out_valid;
	factor_t                   out_factor;
	bank_idx_t [MAX_LANES-1:0] out_bank_index;
	sample_t   [MAX_LANES-1:0] out_real;
	sample_t   [MAX_LANES-1:0] out_imag;
	logic                      rd_end;

	// reference sample memory
	sample_t model_real [MAX_N];
	sample_t model_imag [MAX_N];
	integer  seed = 32'h723c_78d8;

	// factor sets under test
	int set_nf [3][MAX_STAGES] = '{'{4, 4, 4, 0, 0}, '{5, 3, 2, 0, 0}, '{2, 3, 4, 5, 0}};
	int set_num [3] = '{3, 3, 4};
	int cur_nf [MAX_STAGES];
	int cur_num;

	// expected stream of the running stage
	logic armed;
	logic prev_valid;
	int   exp_stride, exp_span, exp_groups, exp_factor;
	int   beat_cnt, end_cnt, ack_cnt, req_cnt;

	mrd_read_top u_mrd_read_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_i       (wb_dat_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack         (wb_ack),
		.out_valid      (out_valid),
		.out_factor     (out_factor),
		.out_bank_index (out_bank_index),
		.out_real       (out_real),
		.out_imag       (out_imag),
		.rd_end         (rd_end)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// ----------------------------------------
	// wishbone host
	// ----------------------------------------
	ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else stop_on_error($sformatf("MISMATCH at %0t: wb_ack high twice in a row", $time));
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else stop_on_error($sformatf("MISMATCH at %0t: wb_ack without request", $time));

	always @(posedge clk)
	begin
		if (rst_n && wb_ack)
			ack_cnt <= ack_cnt + 1;
	end

	task automatic wb_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
		output wb_data_t rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_i <= dat;
		req_cnt++;
		do
		begin
			@(posedge clk);
			waited++;
			if (waited > 16)
				stop_on_error("no wb_ack within 16 cycles of a request");
		end
		while (!wb_ack);
		// ack is high in the cycle after the slave sees the request
		assert (waited == 2)
			else stop_on_error($sformatf("MISMATCH at %0t: wb_ack after %0d cycles",
				$time, waited));
		rdat = wb_dat_o;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk);
		assert (ack_cnt == req_cnt)
			else stop_on_error($sformatf("MISMATCH at %0t: %0d acks for %0d requests",
				$time, ack_cnt, req_cnt));
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		wb_data_t unused;
		wb_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
		wb_cycle(1'b0, adr, '0, dat);
	endtask

	// ----------------------------------------
	// stream checker
	// ----------------------------------------
	always @(negedge clk)
	begin : stream_check
		int         base;
		int         addr;
		logic [7:0] used;
		if (rst_n && out_valid)
		begin
			assert (armed && beat_cnt < exp_groups)
				else stop_on_error($sformatf("MISMATCH at %0t: extra beat %0d", $time, beat_cnt));
			assert (beat_cnt == 0 || prev_valid)
				else stop_on_error($sformatf("MISMATCH at %0t: gap in out_valid run", $time));
			assert (out_factor == exp_factor)
				else stop_on_error($sformatf("MISMATCH at %0t: out_factor %0d, expected %0d",
					$time, out_factor, exp_factor));
			base = (beat_cnt / exp_stride) * exp_span + beat_cnt % exp_stride;
			used = '0;
			for (int m = 0; m < MAX_LANES; m++)
			begin
				if (m < exp_factor)
				begin
					addr = base + m * exp_stride;
					assert (out_real[m] == model_real[addr] && out_imag[m] == model_imag[addr])
						else stop_on_error($sformatf("MISMATCH at %0t: beat %0d lane %0d addr %0d",
							$time, beat_cnt, m, addr));
					assert (out_bank_index[m] == addr % NUM_BANKS && !used[out_bank_index[m]])
						else stop_on_error($sformatf("MISMATCH at %0t: lane %0d bank %0d, addr %0d",
							$time, m, out_bank_index[m], addr));
					used[out_bank_index[m]] = 1'b1;
				end
				else
				begin
					assert (out_bank_index[m] == BANK_NONE
						&& out_real[m] == '0 && out_imag[m] == '0)
						else stop_on_error($sformatf("MISMATCH at %0t: unused lane %0d not idle",
							$time, m));
				end
			end
			beat_cnt++;
		end
		if (rst_n && rd_end)
		begin
			// pulse directly after the final beat
			assert (armed && beat_cnt == exp_groups && prev_valid && !out_valid)
				else stop_on_error($sformatf("MISMATCH at %0t: rd_end after %0d of %0d beats",
					$time, beat_cnt, exp_groups));
			end_cnt++;
		end
		prev_valid = out_valid;
	end

	// ----------------------------------------
	// one butterfly stage
	// ----------------------------------------
	task automatic run_stage(input int stg, input int n, input logic restart);
		wb_data_t st;
		int       waited;
		exp_factor = cur_nf[stg];
		exp_stride = 1;
		for (int j = stg + 1; j < cur_num; j++)
			exp_stride *= cur_nf[j];
		exp_span   = exp_stride * exp_factor;
		exp_groups = n / exp_factor;
		beat_cnt   = 0;
		end_cnt    = 0;
		armed      = 1'b1;
		wb_write(REG_CONTROL, (stg << CTRL_STAGE_LSB) | 1);
		wb_read(REG_STATUS, st);
		assert (st[STAT_BUSY] && st[STAT_STAGE_LSB +: 3] == stg)
			else stop_on_error($sformatf("MISMATCH at %0t: status %h after start", $time, st));
		if (restart)
		begin
			// second start lands mid stage and must be dropped
			wb_write(REG_CONTROL, (((stg + 1) % cur_num) << CTRL_STAGE_LSB) | 1);
			wb_read(REG_STATUS, st);
			assert (st[STAT_BUSY] && st[STAT_STAGE_LSB +: 3] == stg)
				else stop_on_error($sformatf("MISMATCH at %0t: status %h after restart",
					$time, st));
		end
		waited = 0;
		while (end_cnt == 0)
		begin
			@(posedge clk);
			waited++;
			if (waited > 4000)
				stop_on_error($sformatf("stage %0d did not finish within 4000 cycles", stg));
		end
		wb_read(REG_STATUS, st);
		assert (!st[STAT_BUSY])
			else stop_on_error($sformatf("MISMATCH at %0t: still busy after rd_end", $time));
		assert (end_cnt == 1 && beat_cnt == exp_groups)
			else stop_on_error($sformatf("MISMATCH at %0t: %0d rd_end pulses, %0d beats",
				$time, end_cnt, beat_cnt));
		armed = 1'b0;
	endtask

	initial
	begin
		wb_data_t rd_val;
		wb_data_t fact_word;
		integer   smp;
		int       n;
		rst_n      = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_i   = '0;
		armed      = 1'b0;
		prev_valid = 1'b0;
		beat_cnt   = 0;
		end_cnt    = 0;
		ack_cnt    = 0;
		req_cnt    = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		wb_read(REG_STATUS, rd_val);
		assert (!rd_val[STAT_BUSY])
			else stop_on_error($sformatf("MISMATCH at %0t: busy after reset", $time));

		for (int s = 0; s < 3; s++)
		begin
			n         = 1;
			cur_num   = set_num[s];
			fact_word = set_num[s];
			for (int j = 0; j < MAX_STAGES; j++)
			begin
				cur_nf[j] = set_nf[s][j];
				if (j < cur_num)
					n *= cur_nf[j];
				fact_word |= set_nf[s][j] << (FACT_NF_LSB + FACT_NF_STRIDE * j);
			end
			// fresh samples for every factor set
			for (int a = 0; a < n; a++)
			begin
				smp = $random(seed);
				model_real[a] = smp[15:0];
				model_imag[a] = smp[31:16];
				wb_write(wb_addr_t'(a), smp);
			end
			wb_write(REG_FACTORS, fact_word);
			wb_read(REG_FACTORS, rd_val);
			assert (rd_val == fact_word)
				else stop_on_error($sformatf("MISMATCH at %0t: factors read %h, expected %h",
					$time, rd_val, fact_word));
			// memory region reads back as zero
			wb_read(wb_addr_t'(n - 1), rd_val);
			assert (rd_val == '0)
				else stop_on_error($sformatf("MISMATCH at %0t: memory read gave %h",
					$time, rd_val));
			for (int stg = 0; stg < cur_num; stg++)
				run_stage(stg, n, s == 0 && stg == 0);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* build.f */
rtl/mrd_pkg.sv
rtl/mrd_bank_rd_if.sv
rtl/mrd_group_if.sv
rtl/mrd_div7.sv
rtl/mrd_bank_mem.sv
rtl/mrd_addr_gen.sv
rtl/mrd_fsm_rd.sv
rtl/mrd_wb_regs.sv
rtl/mrd_read_top.sv
testbench/tb_mrd_read.sv

/* Bender.yml */
package:
  name: mrd_read

sources:
  - rtl/mrd_pkg.sv
  - rtl/mrd_bank_rd_if.sv
  - rtl/mrd_group_if.sv
  - rtl/mrd_div7.sv
  - rtl/mrd_bank_mem.sv
  - rtl/mrd_addr_gen.sv
  - rtl/mrd_fsm_rd.sv
  - rtl/mrd_wb_regs.sv
  - rtl/mrd_read_top.sv
  - target: simulation
    files:
      - testbench/tb_mrd_read.sv
